// ==== mipsPipe.f ====
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/hazardUnit.sv
source/regFile.sv
source/executeUnit.sv
source/fetchUnit.sv
source/mipsCore.sv
verif/clockGen.sv
verif/mipsCoreTb.sv

// ==== verif/mipsCoreTb.sv ====
`timescale 1ns/100ps
`include "mipsPipe_cfg.svh"

module mipsCoreTb;
    localparam int traceTimeout = 50;
    localparam int imemWords = 128;

    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opJal  = 6'h03;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opBne  = 6'h05;
    localparam logic [5:0] opOri  = 6'h0d;
    localparam logic [5:0] opLui  = 6'h0f;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2b;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef struct packed {
        logic [2:0]  group;
        logic [4:0]  num;
        logic [31:0] value;
        logic [31:0] pc;
    } traceT;

    logic        clk, reset;
    logic [31:0] imAddr, imData, memAddr, memReadData, memWriteData;
    logic [3:0]  memWriteEnable;
    logic        grfWriteEnable;
    logic [4:0]  grfWriteNumber;
    logic [31:0] grfWriteData, grfPc;

    logic [31:0] progTable [imemWords];
    logic [31:0] imem [imemWords];
    logic [31:0] dmem [256];
    logic [31:0] imIndex;
    logic [31:0] gpr [32];  // expected register state
    traceT       expected [$];
    int          progLen, curGroup;
    int          errors, groupErrors, checks, storeCount;
    string       groupNames [5] = '{"alu and immediate", "forwarding", "load use",
                                    "branches", "jumps"};

    clockGen clocks (.clk(clk), .reset(reset));

    mipsCore DUT (
        .clk(clk),
        .reset(reset),
        .imAddr(imAddr),
        .imData(imData),
        .memAddr(memAddr),
        .memReadData(memReadData),
        .memWriteData(memWriteData),
        .memWriteEnable(memWriteEnable),
        .grfWriteEnable(grfWriteEnable),
        .grfWriteNumber(grfWriteNumber),
        .grfWriteData(grfWriteData),
        .grfPc(grfPc)
    );

    assign imIndex = (imAddr - `RESET_PC) >> 2;
    assign imData = (imIndex < imemWords) ? imem[imIndex[6:0]] : `NOP_WORD;
    assign memReadData = dmem[memAddr[9:2]];

    always @(posedge clk) begin
        if (!reset && memWriteEnable != 4'b0000) begin
            storeCount++;
            assert (memWriteEnable == 4'b1111) else begin
                $display("CHECK FAILED at %0t: store byte enables %b", $time, memWriteEnable);
                errors++;
                groupErrors++;
            end
            dmem[memAddr[9:2]] <= memWriteData;
        end
    end

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] pcAt(input int idx);
        return `RESET_PC + 32'(4 * idx);
    endfunction

    function automatic string verdict(input int n);
        return (n == 0) ? "ok" : $sformatf("%0d errors", n);
    endfunction

    task automatic emit(input logic [31:0] word);
        progTable[progLen] = word;
        progLen++;
    endtask

    task automatic expectWrite(input logic [4:0] num, input logic [31:0] value,
                               input logic [31:0] pc);
        gpr[num] = value;
        expected.push_back('{group: 3'(curGroup), num: num, value: value, pc: pc});
    endtask

    task automatic runRType(input logic [5:0] funct, input logic [4:0] rd,
                            input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        x = gpr[rs];
        y = gpr[rt];
        case (funct)
            fnAddu:  r = x + y;
            fnSubu:  r = x - y;
            fnAnd:   r = x & y;
            fnOr:    r = x | y;
            fnSlt:   r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        emit(encodeR(funct, rd, rs, rt));
        if (rd != 5'd0) expectWrite(rd, r, pcAt(progLen - 1));  // $0 leaves no trace
    endtask

    task automatic runOri(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        emit(encodeI(opOri, rt, rs, imm));
        expectWrite(rt, gpr[rs] | {16'h0000, imm}, pcAt(progLen - 1));
    endtask

    task automatic runLui(input logic [4:0] rt, input logic [15:0] imm);
        emit(encodeI(opLui, rt, 5'd0, imm));
        expectWrite(rt, {imm, 16'h0000}, pcAt(progLen - 1));
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
            groupErrors++;
        end
    endtask

    task automatic waitForTrace(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < traceTimeout) begin
            @(negedge clk);  // trace is stable mid-cycle
            cycles++;
            seen = grfWriteEnable;
        end
    endtask

    initial begin
        logic [15:0] a, b, c, d;
        logic [31:0] retPc;
        logic        seen;
        logic        timedOut;
        int          cycles;

        void'($urandom(32'h89aa_ed3f));
        errors = 0;
        groupErrors = 0;
        checks = 0;
        storeCount = 0;
        progLen = 0;
        timedOut = 1'b0;
        for (int i = 0; i < imemWords; i++) progTable[i] = `NOP_WORD;
        for (int i = 0; i < 256; i++) dmem[i] = $urandom;
        for (int i = 0; i < 32; i++) gpr[i] = '0;
        a = 16'($urandom);
        b = 16'($urandom);
        c = 16'($urandom);
        d = 16'($urandom);

        curGroup = 0;
        runOri(1, 0, a);
        runLui(2, b);
        runOri(2, 2, c);
        runLui(3, d);
        runRType(fnAddu, 4, 1, 2);
        runRType(fnSubu, 5, 1, 2);
        runRType(fnAnd, 6, 2, 3);
        runRType(fnOr, 7, 1, 3);
        runRType(fnSlt, 8, 2, 3);
        runRType(fnSlt, 9, 3, 2);
        runRType(fnAddu, 0, 1, 2);

        curGroup = 1;
        runRType(fnAddu, 10, 4, 5);
        runRType(fnSubu, 11, 10, 1);
        runRType(fnOr, 12, 11, 10);
        runRType(fnAddu, 12, 12, 12);
        runRType(fnSlt, 13, 12, 11);

        curGroup = 2;
        runOri(14, 0, 16'h0100);  // data base address
        emit(encodeI(opSw, 12, 14, 16'd4));
        emit(encodeI(opLw, 15, 14, 16'd4));
        expectWrite(15, gpr[12], pcAt(progLen - 1));
        runRType(fnAddu, 16, 15, 1);
        emit(encodeI(opLw, 17, 14, 16'd8));
        expectWrite(17, dmem[66], pcAt(progLen - 1));
        runRType(fnSubu, 18, 17, 16);

        curGroup = 3;
        runOri(19, 0, a);
        emit(encodeI(opBeq, 1, 19, 16'd2));  // taken
        runOri(20, 0, 16'd1);
        emit(encodeI(opOri, 21, 0, 16'd2));  // skipped
        runOri(21, 0, 16'd3);
        emit(encodeI(opBne, 1, 19, 16'd2));  // not taken
        runOri(22, 0, 16'd4);
        runOri(23, 0, 16'd5);
        runOri(24, 0, 16'd6);
        emit(encodeI(opBne, 0, 24, 16'd2));  // taken
        runOri(25, 0, 16'd7);
        emit(encodeI(opOri, 26, 0, 16'd8));  // skipped
        emit(encodeI(opBeq, 0, 25, 16'd2));  // not taken
        runOri(26, 0, 16'd9);
        runOri(27, 0, 16'd10);

        curGroup = 4;
        emit(encodeJ(opJal, pcAt(96)));
        expectWrite(31, pcAt(progLen - 1) + 32'd8, pcAt(progLen - 1));
        runOri(28, 0, 16'd11);
        retPc = pcAt(progLen);
        emit(encodeI(opOri, 29, 0, 16'd12));
        emit(encodeJ(opJ, pcAt(104)));
        emit(encodeI(opOri, 20, 0, 16'd15));
        progLen = 96;  // subroutine
        emit(encodeR(fnJr, 0, 31, 0));
        runRType(fnAddu, 30, 31, 0);
        expectWrite(29, 32'd12, retPc);
        expectWrite(20, 32'd15, retPc + 32'd8);
        progLen = 104;  // jump target
        runOri(26, 0, 16'd14);

        for (int i = 0; i < imemWords; i++) imem[i] = progTable[i];

        cycles = 0;
        while (reset && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("reset was never released");
            timedOut = 1'b1;
        end

        for (int i = 0; i < expected.size() && !timedOut; i++) begin
            waitForTrace(seen);
            if (!seen) begin
                $display("timeout: register write %0d never appeared", i);
                timedOut = 1'b1;
            end else begin
                checkEqual("write number", 32'(grfWriteNumber), 32'(expected[i].num));
                checkEqual("write data", grfWriteData, expected[i].value);
                checkEqual("write pc", grfPc, expected[i].pc);
                if (i == expected.size() - 1 || expected[i + 1].group != expected[i].group) begin
                    if (expected[i].group == 3'd2) checkEqual("store count", storeCount, 1);
                    $display("%s: %s", groupNames[expected[i].group], verdict(groupErrors));
                    groupErrors = 0;
                end
            end
        end

        if (!timedOut) begin
            for (int k = 0; k < 20; k++) begin
                @(negedge clk);
                checks++;
                assert (!grfWriteEnable) else begin
                    $display("CHECK FAILED at %0t: extra write to register %0d",
                             $time, grfWriteNumber);
                    errors++;
                    groupErrors++;
                end
            end
            $display("no extra writes: %s", verdict(groupErrors));
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;  // released just after the third edge
    end

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/100ps
`include "mipsPipe_cfg.svh"

module mipsCore (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imAddr,
    input  logic [31:0] imData,
    output logic [31:0] memAddr,
    input  logic [31:0] memReadData,
    output logic [31:0] memWriteData,
    output logic [3:0]  memWriteEnable,
    output logic        grfWriteEnable,
    output logic [4:0]  grfWriteNumber,
    output logic [31:0] grfWriteData,
    output logic [31:0] grfPc
);
    import isaPkg::*;
    import pipePkg::*;

    localparam decExReg bubbleDe = '{pc: '0, instr: `NOP_WORD, ctrl: '0,
                                     rsData: '0, rtData: '0};
    localparam exMemReg bubbleEm = '{pc: '0, instr: `NOP_WORD, ctrl: '0,
                                     result: '0, rtData: '0};
    localparam memWbReg bubbleMw = '{pc: '0, instr: `NOP_WORD, ctrl: '0,
                                     result: '0, loadData: '0};

    logic [31:0] fetchPc;
    logic [31:0] decodePc;
    instrWord    decodeInstr;
    ctrlWord     decodeCtrl;
    logic [31:0] rfRs, rfRt, decRs, decRt;

    decExReg deStage;
    exMemReg emStage;
    memWbReg mwStage;

    logic   stall;
    fwdSelT fwdDecRs, fwdDecRt, fwdExRs, fwdExRt, fwdMemRt;

    logic [31:0] exFwd, exRs, exRt, aluResult, exResult;
    logic [31:0] memRt, wbData;

    function automatic logic [31:0] fwdMux(
        input fwdSelT      sel,
        input logic [31:0] own,
        input logic [31:0] exVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            fromExecute:   return exVal;
            fromMemory:    return memVal;
            fromWriteback: return wbVal;
            default:       return own;
        endcase
    endfunction

    // one stage closer to having the result
    function automatic ctrlWord ageCtrl(input ctrlWord c);
        ctrlWord aged;
        aged = c;
        if (aged.ready > 0) aged.ready = aged.ready - timeT'(1);
        return aged;
    endfunction

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .decodePc(decodePc),
        .decodeInstr(decodeInstr),
        .branch(decodeCtrl.branch),
        .jump(decodeCtrl.jump),
        .rsData(decRs),
        .rtData(decRt),
        .pc(fetchPc)
    );
    assign imAddr = fetchPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            decodePc <= '0;
            decodeInstr <= `NOP_WORD;
        end else if (!stall) begin
            decodePc <= fetchPc;
            decodeInstr <= imData;
        end
    end

    instrDecoder decoder (.instr(decodeInstr), .ctrl(decodeCtrl));

    regFile grf (
        .clk(clk),
        .reset(reset),
        .readNumber1(decodeInstr.rFmt.rs),
        .readNumber2(decodeInstr.rFmt.rt),
        .writeEnable(mwStage.ctrl.writeEnable),
        .writeNumber(mwStage.ctrl.writeNumber),
        .writeData(wbData),
        .readData1(rfRs),
        .readData2(rfRt)
    );

    hazardUnit hazard (
        .decodeInstr(decodeInstr),
        .decodeCtrl(decodeCtrl),
        .exInstr(deStage.instr),
        .exCtrl(deStage.ctrl),
        .memInstr(emStage.instr),
        .memCtrl(emStage.ctrl),
        .wbCtrl(mwStage.ctrl),
        .stall(stall),
        .fwdDecRs(fwdDecRs),
        .fwdDecRt(fwdDecRt),
        .fwdExRs(fwdExRs),
        .fwdExRt(fwdExRt),
        .fwdMemRt(fwdMemRt)
    );

    assign exFwd = deStage.pc + 32'd8;  // only link values are ready in execute
    assign decRs = fwdMux(fwdDecRs, rfRs, exFwd, emStage.result, wbData);
    assign decRt = fwdMux(fwdDecRt, rfRt, exFwd, emStage.result, wbData);

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            deStage <= bubbleDe;
        end else begin
            deStage <= '{pc: decodePc, instr: decodeInstr, ctrl: decodeCtrl,
                         rsData: decRs, rtData: decRt};
        end
    end

    assign exRs = fwdMux(fwdExRs, deStage.rsData, exFwd, emStage.result, wbData);
    assign exRt = fwdMux(fwdExRt, deStage.rtData, exFwd, emStage.result, wbData);

    executeUnit alu (
        .ctrl(deStage.ctrl),
        .rsData(exRs),
        .rtData(exRt),
        .imm(deStage.instr.iFmt.imm),
        .result(aluResult)
    );
    assign exResult = (deStage.ctrl.regSrc == srcLink) ? exFwd : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            emStage <= bubbleEm;
        end else begin
            emStage <= '{pc: deStage.pc, instr: deStage.instr, ctrl: ageCtrl(deStage.ctrl),
                         result: exResult, rtData: exRt};
        end
    end

    assign memRt = fwdMux(fwdMemRt, emStage.rtData, exFwd, emStage.result, wbData);
    assign memAddr = emStage.result;
    assign memWriteData = memRt;
    assign memWriteEnable = {4{emStage.ctrl.memWrite}};  // word stores only

    always_ff @(posedge clk) begin
        if (reset) begin
            mwStage <= bubbleMw;
        end else begin
            mwStage <= '{pc: emStage.pc, instr: emStage.instr, ctrl: ageCtrl(emStage.ctrl),
                         result: emStage.result, loadData: memReadData};
        end
    end

    always_comb begin
        case (mwStage.ctrl.regSrc)
            srcMem:  wbData = mwStage.loadData;
            srcLink: wbData = mwStage.pc + 32'd8;
            default: wbData = mwStage.result;
        endcase
    end

    assign grfWriteEnable = mwStage.ctrl.writeEnable;
    assign grfWriteNumber = mwStage.ctrl.writeNumber;
    assign grfWriteData = wbData;
    assign grfPc = mwStage.pc;

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        memWriteEnable != 4'b0000 |-> memAddr[1:0] == 2'b00)
        else $error("store address not word aligned");

endmodule

// ==== source/fetchUnit.sv ====
`timescale 1ns/100ps
`include "mipsPipe_cfg.svh"

module fetchUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic [31:0]      decodePc,
    input  isaPkg::instrWord decodeInstr,
    input  pipePkg::branchT  branch,
    input  pipePkg::jumpT    jump,
    input  logic [31:0]      rsData,
    input  logic [31:0]      rtData,
    output logic [31:0]      pc
);
    import pipePkg::*;

    logic [31:0] slotPc;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        taken;

    assign slotPc = decodePc + 32'd4;  // delay slot address
    assign branchTarget = slotPc
                        + {{14{decodeInstr.iFmt.imm[15]}}, decodeInstr.iFmt.imm, 2'b00};
    assign jumpTarget = {slotPc[31:28], decodeInstr.jFmt.index, 2'b00};

    assign taken = ((branch == brEq) && (rsData == rtData))
                || ((branch == brNe) && (rsData != rtData));

    always_comb begin
        case (jump)
            jmpIndex: nextPc = jumpTarget;
            jmpReg:   nextPc = rsData;
            default:  nextPc = taken ? branchTarget : pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
    input  pipePkg::ctrlWord ctrl,
    input  logic [31:0]      rsData,
    input  logic [31:0]      rtData,
    input  logic [15:0]      imm,
    output logic [31:0]      result
);
    import pipePkg::*;

    logic [31:0] extImm;
    logic [31:0] operandB;

    assign extImm = ctrl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign operandB = ctrl.aluImm ? extImm : rtData;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  result = rsData + operandB;
            aluSub:  result = rsData - operandB;
            aluAnd:  result = rsData & operandB;
            aluOr:   result = rsData | operandB;
            aluSlt:  result = {31'd0, $signed(rsData) < $signed(operandB)};
            aluLui:  result = {imm, 16'h0000};
            default: result = rsData + operandB;
        endcase
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  readNumber1,
    input  logic [4:0]  readNumber2,
    input  logic        writeEnable,
    input  logic [4:0]  writeNumber,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeNumber != 5'd0) begin
            regs[writeNumber] <= writeData;
        end
    end

    // same-cycle bypass from writeback
    assign readData1 = (writeEnable && writeNumber == readNumber1 && readNumber1 != 5'd0)
                     ? writeData : regs[readNumber1];
    assign readData2 = (writeEnable && writeNumber == readNumber2 && readNumber2 != 5'd0)
                     ? writeData : regs[readNumber2];

    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        writeEnable |-> writeNumber != 5'd0)
        else $error("write to register 0 reached the register file");

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  isaPkg::instrWord decodeInstr,
    input  pipePkg::ctrlWord decodeCtrl,
    input  isaPkg::instrWord exInstr,
    input  pipePkg::ctrlWord exCtrl,
    input  isaPkg::instrWord memInstr,
    input  pipePkg::ctrlWord memCtrl,
    input  pipePkg::ctrlWord wbCtrl,
    output logic             stall,
    output pipePkg::fwdSelT  fwdDecRs,
    output pipePkg::fwdSelT  fwdDecRt,
    output pipePkg::fwdSelT  fwdExRs,
    output pipePkg::fwdSelT  fwdExRt,
    output pipePkg::fwdSelT  fwdMemRt
);
    import pipePkg::*;

    localparam ctrlWord noWriter = '0;

    function automatic logic hit(input ctrlWord c, input logic [4:0] r);
        return c.writeEnable && (c.writeNumber == r) && (r != 5'd0);
    endfunction

    // nearest writer wins, even while its value is still on the way
    function automatic fwdSelT pickSource(
        input logic [4:0] r,
        input ctrlWord    c1,
        input fwdSelT     s1,
        input ctrlWord    c2,
        input fwdSelT     s2,
        input ctrlWord    c3,
        input fwdSelT     s3
    );
        fwdSelT sel;
        sel = fwdNone;
        if (hit(c1, r)) begin
            if (c1.ready == 0) sel = s1;
        end else if (hit(c2, r)) begin
            if (c2.ready == 0) sel = s2;
        end else if (hit(c3, r)) begin
            if (c3.ready == 0) sel = s3;
        end
        return sel;
    endfunction

    function automatic logic late(input logic [4:0] r, input timeT useTime);
        if (hit(exCtrl, r)) return exCtrl.ready > useTime;
        if (hit(memCtrl, r)) return memCtrl.ready > useTime;
        return 1'b0;  // writeback always has its value
    endfunction

    always_comb begin
        stall = late(decodeInstr.rFmt.rs, decodeCtrl.useRs)
             || late(decodeInstr.rFmt.rt, decodeCtrl.useRt);
    end

    assign fwdDecRs = pickSource(decodeInstr.rFmt.rs, exCtrl, fromExecute,
                                 memCtrl, fromMemory, wbCtrl, fromWriteback);
    assign fwdDecRt = pickSource(decodeInstr.rFmt.rt, exCtrl, fromExecute,
                                 memCtrl, fromMemory, wbCtrl, fromWriteback);
    assign fwdExRs = pickSource(exInstr.rFmt.rs, memCtrl, fromMemory,
                                wbCtrl, fromWriteback, noWriter, fwdNone);
    assign fwdExRt = pickSource(exInstr.rFmt.rt, memCtrl, fromMemory,
                                wbCtrl, fromWriteback, noWriter, fwdNone);
    assign fwdMemRt = pickSource(memInstr.rFmt.rt, wbCtrl, fromWriteback,
                                 noWriter, fwdNone, noWriter, fwdNone);

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
    input  isaPkg::instrWord instr,
    output pipePkg::ctrlWord ctrl
);
    import isaPkg::*;
    import pipePkg::*;

    logic [4:0] dest;
    logic       writes;

    always_comb begin
        ctrl = '0;
        ctrl.useRs = timeNever;
        ctrl.useRt = timeNever;
        dest = instr.iFmt.rt;  // i-format target
        writes = 1'b0;
        case (instr.rFmt.opcode)
            opSpecial: begin
                dest = instr.rFmt.rd;
                case (instr.rFmt.funct)
                    fnAddu, fnSubu, fnAnd, fnOr, fnSlt: begin
                        writes = 1'b1;
                        ctrl.useRs = timeT'(1);
                        ctrl.useRt = timeT'(1);
                        ctrl.ready = timeT'(1);
                    end
                    fnJr: begin
                        ctrl.jump = jmpReg;
                        ctrl.useRs = timeT'(0);  // resolved in decode
                    end
                    default: ;
                endcase
                case (instr.rFmt.funct)
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opOri: begin
                writes = 1'b1;
                ctrl.aluOp = aluOr;
                ctrl.aluImm = 1'b1;
                ctrl.zeroExt = 1'b1;
                ctrl.useRs = timeT'(1);
                ctrl.ready = timeT'(1);
            end
            opLui: begin
                writes = 1'b1;
                ctrl.aluOp = aluLui;
                ctrl.aluImm = 1'b1;
                ctrl.ready = timeT'(1);
            end
            opLw: begin
                writes = 1'b1;
                ctrl.aluImm = 1'b1;
                ctrl.regSrc = srcMem;
                ctrl.useRs = timeT'(1);
                ctrl.ready = timeT'(2);  // data arrives after memory
            end
            opSw: begin
                ctrl.aluImm = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.useRs = timeT'(1);
                ctrl.useRt = timeT'(2);  // store data needed in memory stage
            end
            opBeq, opBne: begin
                ctrl.branch = (instr.rFmt.opcode == opBeq) ? brEq : brNe;
                ctrl.useRs = timeT'(0);
                ctrl.useRt = timeT'(0);
            end
            opJ: ctrl.jump = jmpIndex;
            opJal: begin
                writes = 1'b1;
                dest = 5'd31;
                ctrl.jump = jmpIndex;
                ctrl.regSrc = srcLink;
            end
            default: ;
        endcase
        ctrl.writeEnable = writes && (dest != 5'd0);
        ctrl.writeNumber = dest;
    end

endmodule

// ==== source/pipePkg.sv ====
`include "mipsPipe_cfg.svh"

package pipePkg;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;
    typedef enum logic [1:0] {srcAlu, srcMem, srcLink} regSrcT;
    typedef enum logic [1:0] {brNone, brEq, brNe} branchT;
    typedef enum logic [1:0] {jmpNone, jmpIndex, jmpReg} jumpT;
    typedef enum logic [1:0] {fwdNone, fromExecute, fromMemory, fromWriteback} fwdSelT;

    typedef logic signed [`TIME_BITS-1:0] timeT;

    // largest time, means the source is never read
    localparam timeT timeNever = timeT'((1 << (`TIME_BITS - 1)) - 1);

    typedef struct packed {
        aluOpT      aluOp;
        logic       aluImm;       // operand b is the immediate
        logic       zeroExt;
        logic       memWrite;
        regSrcT     regSrc;
        logic       writeEnable;
        logic [4:0] writeNumber;
        branchT     branch;
        jumpT       jump;
        timeT       useRs;
        timeT       useRt;
        timeT       ready;        // counted from execute entry
    } ctrlWord;

    typedef struct packed {
        logic [31:0]      pc;
        isaPkg::instrWord instr;
        ctrlWord          ctrl;
        logic [31:0]      rsData;
        logic [31:0]      rtData;
    } decExReg;

    typedef struct packed {
        logic [31:0]      pc;
        isaPkg::instrWord instr;
        ctrlWord          ctrl;
        logic [31:0]      result;   // alu or link value
        logic [31:0]      rtData;
    } exMemReg;

    typedef struct packed {
        logic [31:0]      pc;
        isaPkg::instrWord instr;
        ctrlWord          ctrl;
        logic [31:0]      result;
        logic [31:0]      loadData;
    } memWbReg;

endpackage

// ==== source/isaPkg.sv ====
package isaPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } rFmtT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] index;
    } jFmtT;

    // one word, three views
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrWord;

endpackage

// ==== include/mipsPipe_cfg.svh ====
`ifndef MIPSPIPE_CFG_SVH
`define MIPSPIPE_CFG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_3000

// sll $0, $0, 0
`define NOP_WORD 32'h0000_0000

// signed use/ready times
`define TIME_BITS 3

`endif
